//--- common/stack_cpu_pkg.sv
/* Shared ISA widths, encodings and request structs of the stack processor.
   Opcode values not listed in opcode_e are undefined and halt the core. */
package stack_cpu_pkg;

    parameter int WORD_WIDTH    = 16;
    parameter int OPCODE_WIDTH  = 5;
    parameter int OPERAND_WIDTH = 11;

    // Encodings 2 and 7 are free
    typedef enum logic [OPCODE_WIDTH-1:0] {
        PUSH   = 5'd0,
        PUSH_I = 5'd1,
        POP    = 5'd3,
        ADD    = 5'd4,
        SUB    = 5'd5,
        MUL    = 5'd6,
        AND    = 5'd8,
        NAND   = 5'd9,
        OR     = 5'd10,
        XOR    = 5'd11,
        CMP    = 5'd12,
        NOT    = 5'd13,
        GOTO   = 5'd14,
        IF_EQ  = 5'd15,
        IF_GT  = 5'd16,
        IF_LT  = 5'd17,
        IF_GE  = 5'd18,
        IF_LE  = 5'd19,
        CALL   = 5'd20,
        RET    = 5'd21
    } opcode_e;

    // Opcode sits in the upper bits of the instruction word
    typedef struct packed {
        opcode_e                  opcode;
        logic [OPERAND_WIDTH-1:0] operand;
    } instr_t;

    typedef struct packed {
        logic                  push;
        logic                  pop;
        logic [WORD_WIDTH-1:0] push_data;
    } stack_req_t;

    typedef struct packed {
        logic                     write;
        logic [OPERAND_WIDTH-1:0] adr;
        logic [WORD_WIDTH-1:0]    store_data;
    } mem_req_t;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_FETCH,
        EXECUTE,
        ALU_PUSH,
        MEM_WAIT,
        HALT
    } ctrl_state_e;

endpackage

//--- core/hw_stack.sv
/* Register LIFO; push on full or pop on empty must be kept off by the user.
   Push and pop together overwrite the top word. */
`timescale 1ns/100ps

module hw_stack #(
    parameter int STACK_DEPTH = 32
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  stack_cpu_pkg::stack_req_t            req,
    output logic [stack_cpu_pkg::WORD_WIDTH-1:0] top,
    output logic [stack_cpu_pkg::WORD_WIDTH-1:0] second,
    output logic                                 second_valid,
    output logic                                 full,
    output logic                                 empty
);
    import stack_cpu_pkg::*;

    localparam int IDX_WIDTH = $clog2(STACK_DEPTH);

    logic [WORD_WIDTH-1:0] mem [STACK_DEPTH];
    logic [IDX_WIDTH:0]    count;
    logic [IDX_WIDTH-1:0]  top_idx;
    logic [IDX_WIDTH-1:0]  second_idx;

    assign top_idx      = IDX_WIDTH'(count - 1'b1);
    assign second_idx   = IDX_WIDTH'(count - 2'd2);
    assign top          = mem[top_idx];
    assign second       = mem[second_idx];
    assign empty        = (count == '0);
    assign full         = (count == (IDX_WIDTH + 1)'(STACK_DEPTH));
    assign second_valid = (count >= 2);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (req.push && !req.pop) begin
            count <= count + 1'b1;
        end else if (req.pop && !req.push) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.push && req.pop) begin
            mem[top_idx] <= req.push_data;
        end else if (req.push) begin
            mem[IDX_WIDTH'(count)] <= req.push_data;
        end
    end

endmodule

//--- core/stack_alu.sv
/* Combinational ALU; T is the top of stack and S the word below it.
   Non-ALU opcodes give zero. */
`timescale 1ns/100ps

module stack_alu (
    input  stack_cpu_pkg::opcode_e               opcode,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] top,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] second,
    output logic [stack_cpu_pkg::WORD_WIDTH-1:0] result
);
    import stack_cpu_pkg::*;

    always_comb begin
        case (opcode)
            ADD:  result = top + second;
            SUB:  result = top - second;
            // Low half only
            MUL:  result = top * second;
            AND:  result = top & second;
            NAND: result = ~(top & second);
            OR:   result = top | second;
            XOR:  result = top ^ second;
            CMP: begin
                if (top == second) begin
                    result = '0;
                end else if ($signed(top) > $signed(second)) begin
                    result = WORD_WIDTH'(1);
                end else begin
                    result = '1;
                end
            end
            NOT:     result = ~top;
            default: result = '0;
        endcase
    end

endmodule

//--- core/stack_control.sv
/* Sequencer for one instruction at a time; halts for good on stack overflow,
   underflow or an undefined opcode until the next reset. */
`timescale 1ns/100ps

module stack_control #(
    parameter int PROG_ADDR_WIDTH = 5
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 instr_valid,
    input  stack_cpu_pkg::instr_t                instr,
    input  logic [PROG_ADDR_WIDTH-1:0]           next_pc,
    input  logic                                 mem_done,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] load_data,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] operand_top,
    input  logic                                 operand_second_valid,
    input  logic                                 operand_full,
    input  logic                                 operand_empty,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] return_top,
    input  logic                                 return_full,
    input  logic                                 return_empty,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] alu_result,
    output logic                                 fetch_start,
    output logic                                 redirect,
    output logic [PROG_ADDR_WIDTH-1:0]           redirect_target,
    output logic                                 mem_start,
    output stack_cpu_pkg::mem_req_t              mem_req,
    output stack_cpu_pkg::stack_req_t            operand_req,
    output stack_cpu_pkg::stack_req_t            return_req,
    output logic                                 halted
);
    import stack_cpu_pkg::*;

    ctrl_state_e state, next_state;

    logic                         jump;
    logic [PROG_ADDR_WIDTH-1:0]   jump_target;
    logic                         branch_taken;
    logic signed [WORD_WIDTH-1:0] branch_value;
    logic [WORD_WIDTH-1:0]        alu_q;

    assign fetch_start  = (state == FETCH);
    assign halted       = (state == HALT);
    assign branch_value = operand_top;

    // Signed test of the popped word against zero
    always_comb begin
        case (instr.opcode)
            IF_EQ:   branch_taken = (branch_value == 0);
            IF_GT:   branch_taken = (branch_value > 0);
            IF_LT:   branch_taken = (branch_value < 0);
            IF_GE:   branch_taken = (branch_value >= 0);
            IF_LE:   branch_taken = (branch_value <= 0);
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        next_state  = state;
        operand_req = '0;
        return_req  = '0;
        mem_start   = 1'b0;
        mem_req     = '0;
        jump        = 1'b0;
        jump_target = PROG_ADDR_WIDTH'(instr.operand);
        case (state)
            FETCH: next_state = WAIT_FETCH;
            WAIT_FETCH: begin
                if (instr_valid) begin
                    next_state = EXECUTE;
                end
            end
            EXECUTE: begin
                next_state = FETCH;
                case (instr.opcode)
                    PUSH_I: begin
                        if (operand_full) begin
                            next_state = HALT;
                        end else begin
                            operand_req.push      = 1'b1;
                            operand_req.push_data = WORD_WIDTH'(instr.operand);
                        end
                    end
                    PUSH: begin
                        // Room is checked now, the push happens on mem_done
                        if (operand_full) begin
                            next_state = HALT;
                        end else begin
                            mem_start   = 1'b1;
                            mem_req.adr = instr.operand;
                            next_state  = MEM_WAIT;
                        end
                    end
                    POP: begin
                        if (operand_empty) begin
                            next_state = HALT;
                        end else begin
                            operand_req.pop    = 1'b1;
                            mem_start          = 1'b1;
                            mem_req.write      = 1'b1;
                            mem_req.adr        = instr.operand;
                            mem_req.store_data = operand_top;
                            next_state         = MEM_WAIT;
                        end
                    end
                    ADD, SUB, MUL, AND, NAND, OR, XOR, CMP: begin
                        if (!operand_second_valid) begin
                            next_state = HALT;
                        end else begin
                            operand_req.pop = 1'b1;
                            next_state      = ALU_PUSH;
                        end
                    end
                    NOT: begin
                        if (operand_empty) begin
                            next_state = HALT;
                        end else begin
                            operand_req.pop = 1'b1;
                            next_state      = ALU_PUSH;
                        end
                    end
                    GOTO: jump = 1'b1;
                    IF_EQ, IF_GT, IF_LT, IF_GE, IF_LE: begin
                        if (operand_empty) begin
                            next_state = HALT;
                        end else begin
                            operand_req.pop = 1'b1;
                            jump            = branch_taken;
                        end
                    end
                    CALL: begin
                        if (return_full) begin
                            next_state = HALT;
                        end else begin
                            return_req.push      = 1'b1;
                            return_req.push_data = WORD_WIDTH'(next_pc);
                            jump                 = 1'b1;
                        end
                    end
                    RET: begin
                        if (return_empty) begin
                            next_state = HALT;
                        end else begin
                            return_req.pop = 1'b1;
                            jump           = 1'b1;
                            jump_target    = return_top[PROG_ADDR_WIDTH-1:0];
                        end
                    end
                    default: next_state = HALT;
                endcase
            end
            ALU_PUSH: begin
                // Two-operand result overwrites the second word in place
                operand_req.push      = 1'b1;
                operand_req.pop       = (instr.opcode != NOT);
                operand_req.push_data = alu_q;
                next_state            = FETCH;
            end
            MEM_WAIT: begin
                if (mem_done) begin
                    operand_req.push      = (instr.opcode == PUSH);
                    operand_req.push_data = load_data;
                    next_state            = FETCH;
                end
            end
            HALT: next_state = HALT;
            default: next_state = HALT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH;
            redirect <= 1'b0;
        end else begin
            state <= next_state;
            if (jump) begin
                redirect <= 1'b1;
            end else if (state == FETCH) begin
                redirect <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (jump) begin
            redirect_target <= jump_target;
        end
        // ALU inputs change once the pop lands
        if (state == EXECUTE) begin
            alu_q <= alu_result;
        end
    end

endmodule

//--- logic/instr_fetch.sv
/* Wishbone classic instruction reader, one word per fetch_start.
   The program counter wraps at the top of the PROG_ADDR_WIDTH space. */
`timescale 1ns/100ps

module instr_fetch #(
    parameter int PROG_ADDR_WIDTH = 5
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                fetch_start,
    input  logic                                redirect,
    input  logic [PROG_ADDR_WIDTH-1:0]          redirect_target,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] instr_data,
    input  logic                                instr_ack,
    output logic                                instr_cyc,
    output logic                                instr_stb,
    output logic [PROG_ADDR_WIDTH-1:0]          instr_adr,
    output logic                                instr_valid,
    output stack_cpu_pkg::instr_t               instr,
    output logic [PROG_ADDR_WIDTH-1:0]          next_pc
);
    import stack_cpu_pkg::*;

    logic [PROG_ADDR_WIDTH-1:0] pc;

    assign instr_stb = instr_cyc;
    assign next_pc   = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            instr_adr   <= '0;
            instr_cyc   <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            if (fetch_start && !instr_cyc) begin
                // Jump target replaces the sequential address
                instr_adr <= redirect ? redirect_target : pc;
                instr_cyc <= 1'b1;
            end else if (instr_cyc && instr_ack) begin
                instr_cyc   <= 1'b0;
                instr_valid <= 1'b1;
                pc          <= instr_adr + 1'b1;
            end
        end
    end

    // Fetched word stays put until the next ack
    always_ff @(posedge clk) begin
        if (instr_cyc && instr_ack) begin
            instr <= instr_t'(instr_data);
        end
    end

endmodule

//--- logic/data_bus_master.sv
/* Wishbone classic data master, one read or write per mem_start.
   Only the low DATA_ADDR_WIDTH bits of the request address reach the bus. */
`timescale 1ns/100ps

module data_bus_master #(
    parameter int DATA_ADDR_WIDTH = 5
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 mem_start,
    input  stack_cpu_pkg::mem_req_t              mem_req,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] dmem_load_data,
    input  logic                                 dmem_ack,
    output logic                                 dmem_cyc,
    output logic                                 dmem_stb,
    output logic                                 dmem_we,
    output logic [DATA_ADDR_WIDTH-1:0]           dmem_adr,
    output logic [stack_cpu_pkg::WORD_WIDTH-1:0] dmem_store_data,
    output logic                                 mem_done,
    output logic [stack_cpu_pkg::WORD_WIDTH-1:0] load_data
);
    import stack_cpu_pkg::*;

    assign dmem_stb = dmem_cyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_cyc <= 1'b0;
            dmem_we  <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (mem_start && !dmem_cyc) begin
                dmem_cyc <= 1'b1;
                dmem_we  <= mem_req.write;
            end else if (dmem_cyc && dmem_ack) begin
                dmem_cyc <= 1'b0;
                dmem_we  <= 1'b0;
                mem_done <= 1'b1;
            end
        end
    end

    // Address and data held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (mem_start && !dmem_cyc) begin
            dmem_adr        <= mem_req.adr[DATA_ADDR_WIDTH-1:0];
            dmem_store_data <= mem_req.store_data;
        end
        if (dmem_cyc && dmem_ack) begin
            load_data <= dmem_load_data;
        end
    end

endmodule

//--- logic/stack_cpu.sv
/* Stack processor top with separate Wishbone instruction and data masters.
   STACK_DEPTH sizes both the operand and the return stack. */
`timescale 1ns/100ps

module stack_cpu #(
    parameter int PROG_ADDR_WIDTH = 5,
    parameter int DATA_ADDR_WIDTH = 5,
    parameter int STACK_DEPTH     = 32
) (
    input  logic                                 clk,
    input  logic                                 reset,
    output logic                                 instr_cyc,
    output logic                                 instr_stb,
    output logic [PROG_ADDR_WIDTH-1:0]           instr_adr,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] instr_data,
    input  logic                                 instr_ack,
    output logic                                 dmem_cyc,
    output logic                                 dmem_stb,
    output logic                                 dmem_we,
    output logic [DATA_ADDR_WIDTH-1:0]           dmem_adr,
    output logic [stack_cpu_pkg::WORD_WIDTH-1:0] dmem_store_data,
    input  logic [stack_cpu_pkg::WORD_WIDTH-1:0] dmem_load_data,
    input  logic                                 dmem_ack,
    output logic                                 halted
);
    import stack_cpu_pkg::*;

    logic                       fetch_start, redirect, instr_valid;
    logic [PROG_ADDR_WIDTH-1:0] redirect_target, next_pc;
    instr_t                     instr;
    logic                       mem_start, mem_done;
    mem_req_t                   mem_req;
    logic [WORD_WIDTH-1:0]      load_data, alu_result;
    stack_req_t                 operand_req, return_req;
    logic [WORD_WIDTH-1:0]      operand_top, operand_second, return_top;
    logic                       operand_second_valid, operand_full, operand_empty;
    logic                       return_full, return_empty;

    // Input side
    instr_fetch #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)) fetch (
        .clk, .reset, .fetch_start, .redirect, .redirect_target,
        .instr_data, .instr_ack, .instr_cyc, .instr_stb, .instr_adr,
        .instr_valid, .instr, .next_pc
    );

    stack_control #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)) control (
        .clk, .reset, .instr_valid, .instr, .next_pc, .mem_done, .load_data,
        .operand_top, .operand_second_valid, .operand_full, .operand_empty,
        .return_top, .return_full, .return_empty, .alu_result,
        .fetch_start, .redirect, .redirect_target, .mem_start, .mem_req,
        .operand_req, .return_req, .halted
    );

    hw_stack #(.STACK_DEPTH(STACK_DEPTH)) operand_stack (
        .clk, .reset, .req(operand_req), .top(operand_top), .second(operand_second),
        .second_valid(operand_second_valid), .full(operand_full), .empty(operand_empty)
    );

    hw_stack #(.STACK_DEPTH(STACK_DEPTH)) return_stack (
        .clk, .reset, .req(return_req), .top(return_top), .second(),
        .second_valid(), .full(return_full), .empty(return_empty)
    );

    stack_alu alu (
        .opcode(instr.opcode), .top(operand_top), .second(operand_second),
        .result(alu_result)
    );

    // Output side
    data_bus_master #(.DATA_ADDR_WIDTH(DATA_ADDR_WIDTH)) data_master (
        .clk, .reset, .mem_start, .mem_req, .dmem_load_data, .dmem_ack,
        .dmem_cyc, .dmem_stb, .dmem_we, .dmem_adr, .dmem_store_data,
        .mem_done, .load_data
    );

endmodule

//--- bench/stack_cpu_asserts.sv
/* Concurrent checks on both Wishbone masters and on the halt state.
   Bound into every stack_cpu instance; failures are counted in failure_count. */
`timescale 1ns/100ps

module stack_cpu_asserts #(
    parameter int PROG_ADDR_WIDTH = 5,
    parameter int DATA_ADDR_WIDTH = 5
) (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 instr_cyc,
    input logic                                 instr_stb,
    input logic [PROG_ADDR_WIDTH-1:0]           instr_adr,
    input logic                                 instr_ack,
    input logic                                 dmem_cyc,
    input logic                                 dmem_stb,
    input logic                                 dmem_we,
    input logic [DATA_ADDR_WIDTH-1:0]           dmem_adr,
    input logic [stack_cpu_pkg::WORD_WIDTH-1:0] dmem_store_data,
    input logic                                 dmem_ack,
    input logic                                 halted
);
    int unsigned failure_count = 0;

    // Request held steady until the slave answers
    instr_hold: assert property (@(posedge clk) disable iff (reset)
        instr_cyc && !instr_ack |=> instr_cyc && $stable(instr_adr))
        else begin
            $error("instruction request changed before ack");
            failure_count++;
        end

    dmem_hold: assert property (@(posedge clk) disable iff (reset)
        dmem_cyc && !dmem_ack |=> dmem_cyc && $stable(dmem_adr) && $stable(dmem_we)
            && $stable(dmem_store_data))
        else begin
            $error("data request changed before ack");
            failure_count++;
        end

    cyc_stb_match: assert property (@(posedge clk) disable iff (reset)
        instr_cyc == instr_stb && dmem_cyc == dmem_stb)
        else begin
            $error("cyc and stb differ");
            failure_count++;
        end

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !instr_cyc && !dmem_cyc && !halted)
        else begin
            $error("bus active or halted just after reset");
            failure_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else begin
            $error("halted dropped without reset");
            failure_count++;
        end

    // No new bus cycle once halted
    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> !$rose(instr_cyc) && !$rose(dmem_cyc))
        else begin
            $error("bus cycle started while halted");
            failure_count++;
        end

endmodule

bind stack_cpu stack_cpu_asserts #(
    .PROG_ADDR_WIDTH(PROG_ADDR_WIDTH),
    .DATA_ADDR_WIDTH(DATA_ADDR_WIDTH)
) wb_checks (.*);

//--- bench/stack_cpu_tb.sv
/* Testbench with Wishbone ROM and RAM models whose acks lag 0 to 3 cycles.
   Each program starts at address 0 and ends on its last store or on halt. */
`timescale 1ns/100ps

module stack_cpu_tb;
    import stack_cpu_pkg::*;

    localparam int PROG_ADDR_WIDTH = 5;
    localparam int DATA_ADDR_WIDTH = 5;
    localparam int WAIT_LIMIT      = 2000;
    localparam opcode_e ALU_OPS [9] = '{ADD, SUB, MUL, AND, NAND, OR, XOR, CMP, NOT};
    localparam opcode_e BRANCH_OPS [5] = '{IF_EQ, IF_GT, IF_LT, IF_GE, IF_LE};

    logic                       clk;
    logic                       reset;
    logic                       instr_cyc, instr_stb;
    logic                       instr_ack = 1'b0;
    logic [PROG_ADDR_WIDTH-1:0] instr_adr;
    logic [WORD_WIDTH-1:0]      instr_data = '0;
    logic                       dmem_cyc, dmem_stb, dmem_we;
    logic                       dmem_ack = 1'b0;
    logic [DATA_ADDR_WIDTH-1:0] dmem_adr;
    logic [WORD_WIDTH-1:0]      dmem_store_data;
    logic [WORD_WIDTH-1:0]      dmem_load_data = '0;
    logic                       halted;

    logic [WORD_WIDTH-1:0] rom [2**PROG_ADDR_WIDTH];
    logic [WORD_WIDTH-1:0] ram [2**DATA_ADDR_WIDTH];
    int                    store_adr_q [$];
    logic [WORD_WIDTH-1:0] store_data_q [$];
    int                    seed = 94583;
    int                    rom_delay, ram_delay;
    bit                    rom_busy, ram_busy;
    int                    error_count, test_count, failed_tests;

    stack_cpu #(
        .PROG_ADDR_WIDTH(PROG_ADDR_WIDTH),
        .DATA_ADDR_WIDTH(DATA_ADDR_WIDTH),
        .STACK_DEPTH(32)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction ROM slave
    always @(posedge clk) begin
        if (reset) begin
            instr_ack <= 1'b0;
            rom_busy = 1'b0;
        end else if (instr_ack) begin
            instr_ack <= 1'b0;
        end else if (instr_cyc) begin
            if (!rom_busy) begin
                rom_delay = {$random(seed)} % 4;
                rom_busy = 1'b1;
            end
            if (rom_delay == 0) begin
                instr_ack  <= 1'b1;
                instr_data <= rom[instr_adr];
                rom_busy = 1'b0;
            end else begin
                rom_delay--;
            end
        end
    end

    // Data RAM slave, every write is logged in order
    always @(posedge clk) begin
        if (reset) begin
            dmem_ack <= 1'b0;
            ram_busy = 1'b0;
        end else if (dmem_ack) begin
            dmem_ack <= 1'b0;
        end else if (dmem_cyc) begin
            if (!ram_busy) begin
                ram_delay = {$random(seed)} % 4;
                ram_busy = 1'b1;
            end
            if (ram_delay == 0) begin
                dmem_ack <= 1'b1;
                ram_busy = 1'b0;
                if (dmem_we) begin
                    ram[dmem_adr] = dmem_store_data;
                    store_adr_q.push_back(dmem_adr);
                    store_data_q.push_back(dmem_store_data);
                end else begin
                    dmem_load_data <= ram[dmem_adr];
                end
            end else begin
                ram_delay--;
            end
        end
    end

    function automatic logic [WORD_WIDTH-1:0] encode(opcode_e op, int operand);
        return {op, OPERAND_WIDTH'(operand)};
    endfunction

    function automatic logic [WORD_WIDTH-1:0] ram_fill(int adr);
        return WORD_WIDTH'(16'hc3a5 ^ (adr * 32'h0b1d));
    endfunction

    // t is the top of stack, s the word pushed before it
    function automatic logic [WORD_WIDTH-1:0] alu_expect(opcode_e op,
                                                         logic [WORD_WIDTH-1:0] t,
                                                         logic [WORD_WIDTH-1:0] s);
        case (op)
            ADD:  return t + s;
            SUB:  return t - s;
            MUL:  return t * s;
            AND:  return t & s;
            NAND: return ~(t & s);
            OR:   return t | s;
            XOR:  return t ^ s;
            CMP:  return (t == s) ? 16'h0000 : (($signed(t) > $signed(s)) ? 16'h0001 : 16'hffff);
            NOT:  return ~t;
            default: return 'x;
        endcase
    endfunction

    function automatic bit branch_taken(opcode_e op, logic signed [WORD_WIDTH-1:0] v);
        case (op)
            IF_EQ:   return v == 0;
            IF_GT:   return v > 0;
            IF_LT:   return v < 0;
            IF_GE:   return v >= 0;
            IF_LE:   return v <= 0;
            default: return 1'b1;
        endcase
    endfunction

    // Unused ROM words spin on their own address
    task automatic clear_rom();
        for (int i = 0; i < 2**PROG_ADDR_WIDTH; i++) begin
            rom[i] = encode(GOTO, i);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        store_adr_q.delete();
        store_data_q.delete();
        for (int i = 0; i < 2**DATA_ADDR_WIDTH; i++) begin
            ram[i] = ram_fill(i);
        end
        reset <= 1'b0;
    endtask

    task automatic wait_for_stores(int count);
        int cycles;
        cycles = 0;
        while (store_adr_q.size() < count && !halted && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("Timed out after %0d cycles waiting for %0d stores", cycles, count);
            error_count++;
        end
    endtask

    task automatic check_store(int idx, int exp_adr, logic [WORD_WIDTH-1:0] exp_data);
        if (idx >= store_adr_q.size()) begin
            $display("Store number %0d never happened (halted = %b)", idx, halted);
            error_count++;
        end else begin
            assert (store_adr_q[idx] == exp_adr) else begin
                $display("ERROR at %0t: dmem_adr = %0d, expected %0d",
                         $time, store_adr_q[idx], exp_adr);
                error_count++;
            end
            assert (store_data_q[idx] == exp_data) else begin
                $display("ERROR at %0t: dmem_store_data = 0x%h, expected 0x%h",
                         $time, store_data_q[idx], exp_data);
                error_count++;
            end
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: pass", name);
        end else begin
            failed_tests++;
            $display("%s: FAIL", name);
        end
    endtask

    task automatic run_alu(opcode_e op);
        logic [WORD_WIDTH-1:0] a, b;
        int errors_before;
        errors_before = error_count;
        a = WORD_WIDTH'({$random(seed)} % 2048);
        b = WORD_WIDTH'({$random(seed)} % 2048);
        clear_rom();
        rom[0] = encode(PUSH_I, a);
        rom[1] = encode(PUSH_I, b);
        rom[2] = encode(op, 0);
        rom[3] = encode(POP, 1);
        apply_reset();
        wait_for_stores(1);
        check_store(0, 1, alu_expect(op, b, a));
        finish_test($sformatf("alu %s a=%0d b=%0d", op.name(), a, b), errors_before);
    endtask

    // kind 0, 1 and 2 put 0, 1 and all ones on the stack; GOTO 2 acts as a no-op
    task automatic run_branch(opcode_e op, int kind);
        logic [WORD_WIDTH-1:0] v;
        int errors_before;
        errors_before = error_count;
        v = (kind == 2) ? '1 : WORD_WIDTH'(kind);
        clear_rom();
        rom[0] = encode(PUSH_I, (kind == 1) ? 1 : 0);
        rom[1] = (kind == 2) ? encode(NOT, 0) : encode(GOTO, 2);
        rom[2] = encode(op, 6);
        rom[3] = encode(PUSH_I, 2);
        rom[4] = encode(POP, 2);
        rom[6] = encode(PUSH_I, 1);
        rom[7] = encode(POP, 2);
        apply_reset();
        wait_for_stores(1);
        check_store(0, 2, branch_taken(op, v) ? 1 : 2);
        finish_test($sformatf("branch %s v=%0d", op.name(), $signed(v)), errors_before);
    endtask

    task automatic run_halt(string name, logic [WORD_WIDTH-1:0] w0, logic [WORD_WIDTH-1:0] w1);
        int errors_before;
        int cycles;
        errors_before = error_count;
        clear_rom();
        rom[0] = w0;
        rom[1] = w1;
        rom[2] = encode(PUSH_I, 9);
        rom[3] = encode(POP, 2);
        apply_reset();
        cycles = 0;
        while (!halted && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: processor never halted", name);
            error_count++;
        end
        // Watch for stray activity after the halt
        repeat (20) @(posedge clk);
        assert (halted) else begin
            $display("ERROR at %0t: halted = %b, expected 1", $time, halted);
            error_count++;
        end
        assert (store_adr_q.size() == 0) else begin
            $display("ERROR at %0t: store count = %0d, expected 0", $time, store_adr_q.size());
            error_count++;
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        int errors_before;
        reset = 1'b1;
        for (int i = 0; i < 9; i++) begin
            run_alu(ALU_OPS[i]);
        end
        // Load from address 3, store to address 7
        errors_before = error_count;
        clear_rom();
        rom[0] = encode(PUSH, 3);
        rom[1] = encode(POP, 7);
        apply_reset();
        wait_for_stores(1);
        check_store(0, 7, ram_fill(3));
        finish_test("copy PUSH 3 to POP 7", errors_before);
        for (int i = 0; i < 5; i++) begin
            for (int k = 0; k < 3; k++) begin
                run_branch(BRANCH_OPS[i], k);
            end
        end
        run_branch(GOTO, 0);
        // Subroutine at 4 stores 5, the caller stores 6 after the return
        errors_before = error_count;
        clear_rom();
        rom[0] = encode(CALL, 4);
        rom[1] = encode(PUSH_I, 6);
        rom[2] = encode(POP, 3);
        rom[4] = encode(PUSH_I, 5);
        rom[5] = encode(POP, 3);
        rom[6] = encode(RET, 0);
        apply_reset();
        wait_for_stores(2);
        check_store(0, 3, 5);
        check_store(1, 3, 6);
        finish_test("call and return", errors_before);
        run_halt("halt on empty POP", encode(POP, 1), encode(GOTO, 2));
        run_halt("halt on ADD with one word", encode(PUSH_I, 4), encode(ADD, 0));
        run_halt("halt on opcode 7", {5'd7, 11'd0}, encode(GOTO, 2));
        repeat (2) @(posedge clk);
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 test_count, failed_tests, error_count, UUT.wb_checks.failure_count);
        if (error_count == 0 && UUT.wb_checks.failure_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- stack_cpu.f
common/stack_cpu_pkg.sv
core/hw_stack.sv
core/stack_alu.sv
core/stack_control.sv
logic/instr_fetch.sv
logic/data_bus_master.sv
logic/stack_cpu.sv
bench/stack_cpu_asserts.sv
bench/stack_cpu_tb.sv
